// File: hdl/soc_pkg.sv
/*
 * Shared bus types, region and device enums,
 * register offsets and memory sizes for the MMIO subsystem
 */

package soc_pkg;

    // Bus word types
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  mask_t;

    // Peripheral payloads
    typedef logic [7:0]  kbd_code_t;
    typedef logic [63:0] usb_report_t;

    // Region from address bits 31..28
    typedef enum logic [3:0] {
        REGION_ROM   = 4'h0,
        REGION_RAM   = 4'h1,
        REGION_DEV   = 4'h2,
        REGION_OTHER = 4'hF
    } region_e;

    // Device from address bits 15..12 inside the peripheral region
    typedef enum logic [3:0] {
        DEV_NONE    = 4'h0,
        DEV_DISPLAY = 4'h1,
        DEV_USB     = 4'h4,
        DEV_KBD     = 4'h5
    } device_e;

    // RAM geometry
    localparam int RAM_WORDS  = 256;
    localparam int RAM_ADDR_W = 8;

    // Keyboard scan-code queue geometry
    localparam int KBD_DEPTH  = 32;
    localparam int KBD_ADDR_W = 5;

    // Register offsets, address bits 11..0
    localparam logic [11:0] OFS_USB_VALID  = 12'h000;
    localparam logic [11:0] OFS_USB_MSW    = 12'h004;
    localparam logic [11:0] OFS_USB_LSW    = 12'h008;
    localparam logic [11:0] OFS_KBD_STATUS = 12'h000;
    localparam logic [11:0] OFS_KBD_CODE   = 12'h004;

endpackage

// File: hdl/bus_decoder.sv
/*
 * Bus request acceptance, region decode, acknowledge and bus error
 * generation, plus the read-data mux for the ack cycle
 */

`timescale 1ns/1ps

module bus_decoder
    import soc_pkg::*;
(
    input  logic  clk,
    input  logic  reset_i,
    input  logic  sel_i,
    input  addr_t addr_i,
    input  logic  we_i,
    input  data_t ram_rdata_i,
    input  data_t dev_rdata_i,
    output logic  ram_req_o,
    output logic  dev_req_o,
    output logic  ack_o,
    output logic  bus_err_o,
    output data_t rdata_o
);

    region_e region;
    region_e region_q;
    logic    accept;
    logic    read_q;
    logic    ack_q;
    logic    err_q;

    function automatic region_e decode_region(input addr_t addr);
        region_e r;
        case (addr[31:28])
            4'h0:    r = REGION_ROM;
            4'h1:    r = REGION_RAM;
            4'h2:    r = REGION_DEV;
            default: r = REGION_OTHER;
        endcase
        return r;
    endfunction

    assign region = decode_region(addr_i);

    // A held request is not taken again during its own ack cycle
    assign accept = sel_i && !ack_q;

    assign ram_req_o = accept && (region == REGION_RAM);
    assign dev_req_o = accept && (region == REGION_DEV);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_q    <= 1'b0;
            err_q    <= 1'b0;
            read_q   <= 1'b0;
            region_q <= REGION_OTHER;
        end else begin
            ack_q <= accept;
            err_q <= accept && (region != REGION_RAM) && (region != REGION_DEV);
            if (accept) begin
                region_q <= region;
                read_q   <= !we_i;
            end
        end
    end

    assign ack_o     = ack_q;
    assign bus_err_o = err_q;

    // Steer the word captured by the selected target; writes return zero
    always_comb begin
        rdata_o = '0;
        if (read_q) begin
            case (region_q)
                REGION_RAM: rdata_o = ram_rdata_i;
                REGION_DEV: rdata_o = dev_rdata_i;
                default:    rdata_o = '0;
            endcase
        end
    end

endmodule

// File: hdl/word_ram.sv
/*
 * Synchronous single-port word RAM with byte write mask
 */

`timescale 1ns/1ps

module word_ram
    import soc_pkg::*;
(
    input  logic  clk,
    input  logic  req_i,
    input  logic  we_i,
    input  addr_t addr_i,
    input  data_t wdata_i,
    input  mask_t wmask_i,
    output data_t rdata_o
);

    data_t                 mem [RAM_WORDS];
    data_t                 rdata_q;
    logic [RAM_ADDR_W-1:0] word_idx;

    // Word index from bits 9..2, higher bits alias
    assign word_idx = addr_i[RAM_ADDR_W+1:2];

    always_ff @(posedge clk) begin
        if (req_i) begin
            if (we_i) begin
                for (int b = 0; b < 4; b++) begin
                    if (wmask_i[b]) begin
                        mem[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
                    end
                end
            end
            // Old contents are returned on a write
            rdata_q <= mem[word_idx];
        end
    end

    assign rdata_o = rdata_q;

endmodule

// File: hdl/kbd_fifo.sv
/*
 * Circular queue of PS/2 scan codes with a last-popped code register
 */

`timescale 1ns/1ps

module kbd_fifo
    import soc_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  kbd_code_t code_i,
    input  logic      push_i,
    input  logic      pop_i,
    output logic      empty_o,
    output kbd_code_t last_code_o
);

    kbd_code_t             mem [KBD_DEPTH];
    logic [KBD_ADDR_W-1:0] wr_ptr;
    logic [KBD_ADDR_W-1:0] rd_ptr;
    logic [KBD_ADDR_W:0]   count;
    logic                  full;
    logic                  do_push;
    logic                  do_pop;
    kbd_code_t             last_code_q;

    assign full    = (count == (KBD_ADDR_W+1)'(KBD_DEPTH));
    assign empty_o = (count == '0);

    // Push to a full queue and pop of an empty one are dropped
    assign do_push = push_i && !full;
    assign do_pop  = pop_i && !empty_o;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= code_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            last_code_q <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr      <= rd_ptr + 1'b1;
                last_code_q <= mem[rd_ptr];
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign last_code_o = last_code_q;

endmodule

// File: hdl/device_regs.sv
/*
 * Peripheral registers: display latch, USB report readback,
 * keyboard status, pop strobe and last-code readback
 */

`timescale 1ns/1ps

module device_regs
    import soc_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,
    input  logic        req_i,
    input  logic        we_i,
    input  addr_t       addr_i,
    input  data_t       wdata_i,
    input  usb_report_t usb_report_i,
    input  logic        usb_valid_i,
    input  logic        kbd_empty_i,
    input  kbd_code_t   kbd_code_i,
    output logic [7:0]  display_o,
    output logic        kbd_pop_o,
    output data_t       rdata_o
);

    device_e     dev;
    logic [11:0] ofs;
    data_t       read_word;
    data_t       rdata_q;
    logic [7:0]  display_q;

    function automatic device_e decode_device(input addr_t addr);
        device_e d;
        case (addr[15:12])
            4'h1:    d = DEV_DISPLAY;
            4'h4:    d = DEV_USB;
            4'h5:    d = DEV_KBD;
            default: d = DEV_NONE;
        endcase
        return d;
    endfunction

    assign dev = decode_device(addr_i);
    assign ofs = addr_i[11:0];

    // Writing the status offset dequeues one code
    assign kbd_pop_o = req_i && we_i && (dev == DEV_KBD) && (ofs == OFS_KBD_STATUS);

    always_comb begin
        read_word = '0;
        case (dev)
            DEV_USB: begin
                if (ofs == OFS_USB_VALID) begin
                    read_word = {31'd0, usb_valid_i};
                end else if (ofs == OFS_USB_MSW) begin
                    read_word = usb_report_i[63:32];
                end else if (ofs == OFS_USB_LSW) begin
                    read_word = usb_report_i[31:0];
                end
            end
            DEV_KBD: begin
                if (ofs == OFS_KBD_STATUS) begin
                    read_word = {31'd0, !kbd_empty_i};
                end else if (ofs == OFS_KBD_CODE) begin
                    read_word = {24'd0, kbd_code_i};
                end
            end
            default: read_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (req_i) begin
            rdata_q <= read_word;
        end
    end

    // Display takes the low byte whatever the offset or mask
    always_ff @(posedge clk) begin
        if (reset_i) begin
            display_q <= 8'd0;
        end else if (req_i && we_i && (dev == DEV_DISPLAY)) begin
            display_q <= wdata_i[7:0];
        end
    end

    assign display_o = display_q;
    assign rdata_o   = rdata_q;

endmodule

// File: hdl/mmio_subsystem.sv
/*
 * MMIO subsystem top: bus decoder, word RAM, keyboard queue
 * and peripheral registers on one clock
 */

`timescale 1ns/1ps

module mmio_subsystem
    import soc_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,
    input  logic        sel_i,
    input  addr_t       addr_i,
    input  logic        we_i,
    input  data_t       wdata_i,
    input  mask_t       wmask_i,
    input  usb_report_t usb_report_i,
    input  logic        usb_valid_i,
    input  kbd_code_t   kbd_code_i,
    input  logic        kbd_strobe_i,
    output logic        ack_o,
    output data_t       rdata_o,
    output logic        bus_err_o,
    output logic [7:0]  display_o
);

    logic      ram_req;
    logic      dev_req;
    data_t     ram_rdata;
    data_t     dev_rdata;
    logic      kbd_pop;
    logic      kbd_empty;
    kbd_code_t kbd_last_code;

    bus_decoder u_decoder (
        .clk         (clk),
        .reset_i     (reset_i),
        .sel_i       (sel_i),
        .addr_i      (addr_i),
        .we_i        (we_i),
        .ram_rdata_i (ram_rdata),
        .dev_rdata_i (dev_rdata),
        .ram_req_o   (ram_req),
        .dev_req_o   (dev_req),
        .ack_o       (ack_o),
        .bus_err_o   (bus_err_o),
        .rdata_o     (rdata_o)
    );

    word_ram u_ram (
        .clk     (clk),
        .req_i   (ram_req),
        .we_i    (we_i),
        .addr_i  (addr_i),
        .wdata_i (wdata_i),
        .wmask_i (wmask_i),
        .rdata_o (ram_rdata)
    );

    // Keyboard strobes push straight into the queue
    kbd_fifo u_kbd_fifo (
        .clk         (clk),
        .reset_i     (reset_i),
        .code_i      (kbd_code_i),
        .push_i      (kbd_strobe_i),
        .pop_i       (kbd_pop),
        .empty_o     (kbd_empty),
        .last_code_o (kbd_last_code)
    );

    device_regs u_dev_regs (
        .clk          (clk),
        .reset_i      (reset_i),
        .req_i        (dev_req),
        .we_i         (we_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .usb_report_i (usb_report_i),
        .usb_valid_i  (usb_valid_i),
        .kbd_empty_i  (kbd_empty),
        .kbd_code_i   (kbd_last_code),
        .display_o    (display_o),
        .kbd_pop_o    (kbd_pop),
        .rdata_o      (dev_rdata)
    );

endmodule

// File: dv/mmio_asserts.sv
/*
 * Bus handshake assertions, bound into the MMIO subsystem top
 */

`timescale 1ns/1ps

module mmio_asserts (
    input logic clk,
    input logic reset_i,
    input logic sel_i,
    input logic ack_i,
    input logic bus_err_i
);

    // Ack is a single-cycle pulse
    ack_single_cycle: assert property (@(posedge clk) disable iff (reset_i)
        ack_i |=> !ack_i)
        else $error("ack_o stayed high for more than one cycle");

    bus_err_with_ack: assert property (@(posedge clk) disable iff (reset_i)
        bus_err_i |-> ack_i)
        else $error("bus_err_o high without ack_o");

    // Every ack follows a cycle with sel high
    ack_after_sel: assert property (@(posedge clk) disable iff (reset_i)
        ack_i |-> $past(sel_i))
        else $error("ack_o high without sel_i in the previous cycle");

    ack_low_after_reset: assert property (@(posedge clk)
        reset_i |=> !ack_i)
        else $error("ack_o high in the cycle after reset");

endmodule

bind mmio_subsystem mmio_asserts u_asserts (
    .clk       (clk),
    .reset_i   (reset_i),
    .sel_i     (sel_i),
    .ack_i     (ack_o),
    .bus_err_i (bus_err_o)
);

// File: dv/tb_top.sv
/*
 * Testbench for the MMIO subsystem: clock, reset, random bus traffic,
 * reference model and compare tasks
 */

`timescale 1ns/1ps

module tb_top
    import soc_pkg::*;
;

    localparam int     CLK_PERIOD_NS = 40;
    localparam int     NUM_TXN       = 2000;
    localparam int     TXN_CYCLES    = 10;
    localparam int     ACK_LIMIT     = 8;
    localparam int     WATCHDOG_NS   = (NUM_TXN + RAM_WORDS) * TXN_CYCLES * CLK_PERIOD_NS;
    localparam integer SEED          = 32'h7cb4_9e4d;

    localparam addr_t DISPLAY_ADDR    = 32'h2000_1000;
    localparam addr_t USB_VALID_ADDR  = 32'h2000_4000;
    localparam addr_t USB_MSW_ADDR    = 32'h2000_4004;
    localparam addr_t USB_LSW_ADDR    = 32'h2000_4008;
    localparam addr_t KBD_STATUS_ADDR = 32'h2000_5000;
    localparam addr_t KBD_CODE_ADDR   = 32'h2000_5004;

    logic        clk;
    logic        reset_i;
    logic        sel_i;
    addr_t       addr_i;
    logic        we_i;
    data_t       wdata_i;
    mask_t       wmask_i;
    usb_report_t usb_report_i;
    logic        usb_valid_i;
    kbd_code_t   kbd_code_i;
    logic        kbd_strobe_i;
    logic        ack_o;
    data_t       rdata_o;
    logic        bus_err_o;
    logic [7:0]  display_o;

    // Reference model state
    integer      seed;
    data_t       ram_model [RAM_WORDS];
    logic [7:0]  display_model;
    kbd_code_t   kbd_q [$];
    kbd_code_t   last_code_model;
    usb_report_t usb_report_model;
    logic        usb_valid_model;

    mmio_subsystem dut (
        .clk          (clk),
        .reset_i      (reset_i),
        .sel_i        (sel_i),
        .addr_i       (addr_i),
        .we_i         (we_i),
        .wdata_i      (wdata_i),
        .wmask_i      (wmask_i),
        .usb_report_i (usb_report_i),
        .usb_valid_i  (usb_valid_i),
        .kbd_code_i   (kbd_code_i),
        .kbd_strobe_i (kbd_strobe_i),
        .ack_o        (ack_o),
        .rdata_o      (rdata_o),
        .bus_err_o    (bus_err_o),
        .display_o    (display_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the bus traffic completed");
        $display("SIMULATION FAILED");
        $fatal(1);
    end

    function automatic logic [31:0] rand32();
        logic [31:0] r;
        r = $random(seed);
        return r;
    endfunction

    // Masked byte merge as the RAM should apply it
    function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                          input mask_t mask);
        data_t w;
        w = old_word;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                w[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return w;
    endfunction

    task automatic abort_run(input string msg);
        $display("Bus failure: %s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("[ERROR] %s expected 0x%08h actual 0x%08h", name, exp, act);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_display(input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("[ERROR] display_o expected 0x%02h actual 0x%02h", exp, act);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_err(input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] bus_err_o expected 0x%0h actual 0x%0h", exp, act);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    // One request; ack is due exactly two falling edges after the drive edge
    task automatic bus_access(input addr_t addr, input logic we, input data_t wdata,
                              input mask_t wmask, output data_t rdata, output logic err);
        int cycles;
        @(posedge clk);
        sel_i   <= 1'b1;
        addr_i  <= addr;
        we_i    <= we;
        wdata_i <= wdata;
        wmask_i <= wmask;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > ACK_LIMIT) begin
                abort_run("no acknowledge arrived for the request");
            end
        end while (!ack_o);
        if (cycles != 2) begin
            abort_run("acknowledge did not come in the cycle after acceptance");
        end
        rdata = rdata_o;
        err   = bus_err_o;
        @(posedge clk);
        sel_i <= 1'b0;
        @(negedge clk);
        if (ack_o) begin
            abort_run("request held through its ack cycle was acknowledged twice");
        end
    endtask

    task automatic pulse_kbd_strobe();
        kbd_code_t   code;
        logic [31:0] r;
        r    = rand32();
        code = r[7:0];
        @(posedge clk);
        kbd_strobe_i <= 1'b1;
        kbd_code_i   <= code;
        @(posedge clk);
        kbd_strobe_i <= 1'b0;
        // Pushes into a full queue are lost
        if (kbd_q.size() < KBD_DEPTH) begin
            kbd_q.push_back(code);
        end
    endtask

    task automatic update_usb();
        usb_report_t rep;
        logic [31:0] r;
        rep = {rand32(), rand32()};
        r   = rand32();
        @(posedge clk);
        usb_report_i <= rep;
        usb_valid_i  <= r[0];
        usb_report_model = rep;
        usb_valid_model  = r[0];
    endtask

    task automatic kbd_pop_and_read();
        data_t rd;
        logic  er;
        bus_access(KBD_STATUS_ADDR, 1'b1, rand32(), 4'hF, rd, er);
        check_err(1'b0, er);
        if (kbd_q.size() > 0) begin
            last_code_model = kbd_q.pop_front();
        end
        bus_access(KBD_CODE_ADDR, 1'b0, '0, 4'h0, rd, er);
        check_data("rdata_o", {24'd0, last_code_model}, rd);
        check_err(1'b0, er);
    endtask

    task automatic random_txn();
        data_t       rd;
        logic        er;
        addr_t       addr;
        data_t       wd;
        logic [31:0] r;
        int          kind;
        int          n;
        r    = rand32();
        wd   = rand32();
        kind = int'(rand32() % 32'd13);
        case (kind)
            0, 1, 2, 3: begin
                addr = 32'h1000_0000 | (r & 32'h0FFF_FFFC);
                bus_access(addr, 1'b1, wd, r[3:0], rd, er);
                check_err(1'b0, er);
                ram_model[addr[9:2]] = merge_bytes(ram_model[addr[9:2]], wd, r[3:0]);
            end
            4, 5, 6: begin
                addr = 32'h1000_0000 | (r & 32'h0FFF_FFFC);
                bus_access(addr, 1'b0, '0, 4'h0, rd, er);
                check_data("rdata_o", ram_model[addr[9:2]], rd);
                check_err(1'b0, er);
            end
            7: begin
                addr = DISPLAY_ADDR | (r & 32'h0000_0FFC);
                bus_access(addr, 1'b1, wd, r[7:4], rd, er);
                check_err(1'b0, er);
                display_model = wd[7:0];
            end
            8: begin
                n = int'(r % 32'd3);
                addr = (n == 0) ? USB_VALID_ADDR : ((n == 1) ? USB_MSW_ADDR : USB_LSW_ADDR);
                bus_access(addr, 1'b0, '0, 4'h0, rd, er);
                if (n == 0) begin
                    check_data("rdata_o", {31'd0, usb_valid_model}, rd);
                end else if (n == 1) begin
                    check_data("rdata_o", usb_report_model[63:32], rd);
                end else begin
                    check_data("rdata_o", usb_report_model[31:0], rd);
                end
                check_err(1'b0, er);
            end
            9: begin
                bus_access(KBD_STATUS_ADDR, 1'b0, '0, 4'h0, rd, er);
                check_data("rdata_o", {31'd0, (kbd_q.size() != 0)}, rd);
                check_err(1'b0, er);
            end
            10: kbd_pop_and_read();
            11: begin
                // Region 0 or 3..F
                n = int'(r % 32'd14);
                addr = {((n == 0) ? 4'h0 : 4'(n + 2)), wd[27:0]};
                bus_access(addr, r[4], wd, r[11:8], rd, er);
                check_data("rdata_o", '0, rd);
                check_err(1'b1, er);
            end
            default: begin
                n = int'(r % 32'd3);
                if (n == 0) begin
                    addr = {16'h2000, 4'(6 + (wd % 32'd10)), r[11:2], 2'b00};
                end else if (n == 1) begin
                    addr = USB_VALID_ADDR + 32'h00C + (wd & 32'h3FC);
                end else begin
                    addr = KBD_STATUS_ADDR + 32'h008 + (wd & 32'h3FC);
                end
                bus_access(addr, 1'b0, '0, 4'h0, rd, er);
                check_data("rdata_o", '0, rd);
                check_err(1'b0, er);
            end
        endcase
        check_display(display_model, display_o);
    endtask

    initial begin
        data_t rd;
        logic  er;
        seed = SEED;
        reset_i      <= 1'b1;
        sel_i        <= 1'b0;
        addr_i       <= '0;
        we_i         <= 1'b0;
        wdata_i      <= '0;
        wmask_i      <= '0;
        usb_report_i <= '0;
        usb_valid_i  <= 1'b0;
        kbd_code_i   <= '0;
        kbd_strobe_i <= 1'b0;
        display_model    = 8'h00;
        last_code_model  = 8'h00;
        usb_report_model = '0;
        usb_valid_model  = 1'b0;

        repeat (4) @(posedge clk);
        reset_i <= 1'b0;
        @(negedge clk);
        if (ack_o) begin
            abort_run("acknowledge was high right after reset");
        end
        check_display(8'h00, display_o);

        // Pop from an empty queue keeps the reset code
        kbd_pop_and_read();

        // Fill every RAM word so later reads are defined
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram_model[i] = rand32();
            bus_access(32'h1000_0000 | addr_t'(i * 4), 1'b1, ram_model[i], 4'hF, rd, er);
            check_err(1'b0, er);
        end

        for (int t = 0; t < NUM_TXN; t++) begin
            random_txn();
            if (rand32() % 32'd2 == 0) begin
                pulse_kbd_strobe();
            end
            if (rand32() % 32'd16 == 0) begin
                update_usb();
            end
        end

        // Drain the queue, then pop it once more while empty
        while (kbd_q.size() > 0) begin
            kbd_pop_and_read();
        end
        bus_access(KBD_STATUS_ADDR, 1'b0, '0, 4'h0, rd, er);
        check_data("rdata_o", 32'd0, rd);
        check_err(1'b0, er);
        kbd_pop_and_read();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: verilog.f
hdl/soc_pkg.sv
hdl/bus_decoder.sv
hdl/word_ram.sv
hdl/kbd_fifo.sv
hdl/device_regs.sv
hdl/mmio_subsystem.sv
dv/mmio_asserts.sv
dv/tb_top.sv

// File: Makefile
TOP = tb_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -o sim_tb

run: build
	./obj_dir/sim_tb | tee sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then exit 1; fi
	@grep -q "SIMULATION PASSED" sim.log

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
